// ==== sources.f ====
hdl/aud_fmt_pkg.sv
hdl/aud_play_pkg.sv
hdl/aud_clk_gen.sv
hdl/aud_dsp.sv
hdl/aud_dac_tx.sv
hdl/aud_player_top.sv
tests/tb_aud_player.sv

// ==== tests/tb_aud_player.sv ====
`default_nettype none

module tb_aud_player
    import aud_fmt_pkg::*;
    import aud_play_pkg::*;
;

    localparam int BCLK_HALF  = 2;
    localparam int FRAME_CYC  = 2 * BCLK_HALF * 2 * FRAME_BITS;  // i_clk cycles per frame
    localparam int WAIT_TMO   = 2 * FRAME_CYC;
    localparam int MEM_WORDS  = 1 << ADDR_W;
    localparam int NUM_ROUNDS = 8;

    logic       i_clk = 1'b0;
    logic       i_rst_n;
    logic       i_start;
    logic       i_pause;
    logic       i_stop;
    logic       i_fast;
    speed_t     i_speed;
    logic       i_interp;
    sample_t    i_sram_data;
    sram_addr_t o_sram_addr;
    logic       o_dac_bclk;
    logic       o_dac_lrck;
    logic       o_dac_dat;

    sample_t mem [0:MEM_WORDS-1];        // external sample sram

    // reference model state
    play_state_t m_state;
    sram_addr_t  m_addr;
    sample_t     m_prev;
    sample_t     m_out;
    int          m_rep;
    int          m_speed;                // 0 already mapped to 1
    logic        m_fast;
    logic        m_interp;

    int          clk_cnt = 0;            // i_clk edges since reset release

    always #4 i_clk = ~i_clk;

    assign i_sram_data = mem[o_sram_addr];  // asynchronous sram read

    aud_player_top #(
        .BCLK_HALF   (BCLK_HALF)
    ) u_aud_player_top (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .i_fast      (i_fast),
        .i_speed     (i_speed),
        .i_interp    (i_interp),
        .i_sram_data (i_sram_data),
        .o_sram_addr (o_sram_addr),
        .o_dac_bclk  (o_dac_bclk),
        .o_dac_lrck  (o_dac_lrck),
        .o_dac_dat   (o_dac_dat)
    );

    task automatic fail_run();
        $display("Verification failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic report_stall(input string what);
        $display("DAC clock stopped: no %s within %0d clock cycles", what, WAIT_TMO);
        fail_run();
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: serialized sample %0d, expected %0d", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_addr(input sram_addr_t got, input sram_addr_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: sram address 0x%05h, expected 0x%05h", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    // bclk and lrck start low and toggle every half period and half frame
    always @(posedge i_clk) begin
        if (i_rst_n) begin
            check_level("o_dac_bclk", o_dac_bclk, logic'((clk_cnt / BCLK_HALF) % 2));
            check_level("o_dac_lrck", o_dac_lrck, logic'((clk_cnt / (FRAME_CYC / 2)) % 2));
            clk_cnt = clk_cnt + 1;
        end
    end

    // prev + (cur - prev) * k / speed truncated toward zero and kept to 16 bits
    function automatic sample_t ramp_value(input sample_t prev, input sample_t cur,
                                           input int k, input int spd);
        int delta;
        int sum;
        delta = int'(cur) - int'(prev);
        sum   = int'(prev) + (delta * k) / spd;
        return sample_t'(sum);
    endfunction

    task automatic model_start();
        if (m_state == S_IDLE) begin
            m_prev  = mem[m_addr];          // address is parked at 0
            m_rep   = 0;
            m_addr  = m_fast ? sram_addr_t'(m_speed) : sram_addr_t'(1);
            m_state = S_PLAY;
        end
    endtask

    task automatic model_frame_step();
        sample_t cur;
        if (m_state == S_PLAY) begin
            cur = mem[m_addr];
            if (m_fast) begin
                m_out  = m_prev;
                m_prev = cur;
                m_addr = m_addr + sram_addr_t'(m_speed);
            end else begin
                if (m_interp == INTERP_LINEAR) begin
                    m_out = ramp_value(m_prev, cur, m_rep, m_speed);
                end else begin
                    m_out = m_prev;
                end
                if (m_rep == m_speed - 1) begin  // last repeat of this word
                    m_rep  = 0;
                    m_addr = m_addr + sram_addr_t'(1);
                    m_prev = cur;
                end else begin
                    m_rep = m_rep + 1;
                end
            end
        end
    endtask

    task automatic set_mode(input logic fast, input speed_t spd, input logic interp);
        @(posedge i_clk);
        i_fast   <= fast;
        i_speed  <= spd;
        i_interp <= interp;
        m_fast   = fast;
        m_speed  = (spd == '0) ? 1 : int'(spd);
        m_interp = interp;
    endtask

    task automatic start_play();
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;                    // seen high by the dsp on this edge
        model_start();
    endtask

    task automatic stop_play();
        @(posedge i_clk);
        i_stop <= 1'b1;
        @(posedge i_clk);
        i_stop <= 1'b0;
        if (m_state == S_PLAY) begin
            m_state = S_IDLE;
            m_addr  = '0;
        end
    endtask

    task automatic hold_pause(input logic on);
        @(posedge i_clk);
        i_pause <= on;
        if (on && m_state == S_PLAY) begin
            m_state = S_PAUSE;
        end else if (!on && m_state == S_PAUSE) begin
            m_state = S_PLAY;
        end
    endtask

    // returns on the clock edge where the dsp takes its frame step
    task automatic wait_frame_start();
        logic last;
        logic found;
        int   cyc;
        last  = o_dac_lrck;
        found = 1'b0;
        cyc   = 0;
        while (!found) begin
            @(posedge i_clk);
            cyc   = cyc + 1;
            found = last && !o_dac_lrck;
            last  = o_dac_lrck;
            if (!found && cyc >= WAIT_TMO) begin
                report_stall("left frame start");
            end
        end
    endtask

    // msb comes one bclk after lrck falls as in i2s
    task automatic read_left_sample(output sample_t s);
        logic last;
        int   rises;
        int   cyc;
        last  = o_dac_bclk;
        rises = 0;
        cyc   = 0;
        s     = '0;
        while (rises < SAMPLE_W + 1) begin
            @(posedge i_clk);
            cyc = cyc + 1;
            if (o_dac_bclk && !last) begin
                if (rises > 0) begin
                    s = {s[SAMPLE_W-2:0], o_dac_dat};
                end
                rises = rises + 1;
            end
            last = o_dac_bclk;
            if (rises < SAMPLE_W + 1 && cyc >= WAIT_TMO) begin
                report_stall("serial data bit");
            end
        end
    endtask

    task automatic run_frames(input int n);
        sample_t got;
        for (int f = 0; f < n; f++) begin
            wait_frame_start();
            model_frame_step();
            read_left_sample(got);
            check_sample(got, m_out);
            check_addr(o_sram_addr, m_addr);  // settled long after the step
        end
    endtask

    initial begin
        logic   fast;
        logic   interp;
        speed_t spd;

        i_rst_n  = 1'b0;
        i_start  = 1'b0;
        i_pause  = 1'b0;
        i_stop   = 1'b0;
        i_fast   = 1'b0;
        i_speed  = speed_t'(1);
        i_interp = INTERP_CONST;

        m_state  = S_IDLE;
        m_addr   = '0;
        m_prev   = '0;
        m_out    = '0;
        m_rep    = 0;
        m_speed  = 1;
        m_fast   = 1'b0;
        m_interp = INTERP_CONST;

        void'($urandom(14647));
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = sample_t'($urandom);
        end

        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);
        check_addr(o_sram_addr, '0);

        run_frames(3);                      // idle so the line stays silent

        for (int round = 0; round < NUM_ROUNDS; round++) begin
            spd = speed_t'($urandom_range(7, 1));
            case (round)
                0: begin
                    fast   = 1'b1;
                    interp = INTERP_CONST;
                end
                1: begin
                    fast   = 1'b0;
                    interp = INTERP_CONST;
                end
                2: begin
                    fast   = 1'b0;
                    interp = INTERP_LINEAR;
                end
                default: begin
                    fast   = logic'($urandom_range(1, 0));
                    interp = logic'($urandom_range(1, 0));
                end
            endcase

            set_mode(fast, spd, interp);
            start_play();
            run_frames(2 * int'(spd) + 2);

            hold_pause(1'b1);               // output and address freeze
            run_frames(3);
            hold_pause(1'b0);
            run_frames(int'(spd) + 2);

            stop_play();                    // back to address 0 with the last sample held
            run_frames(2);
        end

        $display("Verification passed");
        $finish;
    end

endmodule : tb_aud_player

`default_nettype wire

// ==== hdl/aud_player_top.sv ====
`default_nettype none

module aud_player_top
    import aud_fmt_pkg::*;
    import aud_play_pkg::*;
#(
    parameter int BCLK_HALF = 2         // i_clk cycles per half bclk period
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_pause,
    input  logic       i_stop,
    input  logic       i_fast,
    input  speed_t     i_speed,
    input  logic       i_interp,
    input  sample_t    i_sram_data,     // combinational read of o_sram_addr
    output sram_addr_t o_sram_addr,
    output logic       o_dac_bclk,
    output logic       o_dac_lrck,
    output logic       o_dac_dat
);

    wire     bclk_fall;
    wire     lrck_fall;                 // start of each left frame
    sample_t play_sample;

    aud_clk_gen #(
        .BCLK_HALF   (BCLK_HALF)
    ) u_clk_gen (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .o_bclk      (o_dac_bclk),
        .o_lrck      (o_dac_lrck),
        .o_bclk_fall (bclk_fall),
        .o_lrck_fall (lrck_fall)
    );

    aud_dsp u_dsp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .i_fast      (i_fast),
        .i_speed     (i_speed),
        .i_interp    (i_interp),
        .i_lrck_fall (lrck_fall),
        .i_sram_data (i_sram_data),
        .o_sram_addr (o_sram_addr),
        .o_sample    (play_sample)
    );

    aud_dac_tx u_dac_tx (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_bclk_fall (bclk_fall),
        .i_lrck_fall (lrck_fall),
        .i_sample    (play_sample),
        .o_dac_dat   (o_dac_dat)
    );

endmodule : aud_player_top

`default_nettype wire

// ==== hdl/aud_dac_tx.sv ====
`default_nettype none

module aud_dac_tx
    import aud_fmt_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_bclk_fall,
    input  logic    i_lrck_fall,        // always coincides with a bclk fall
    input  sample_t i_sample,
    output logic    o_dac_dat
);

    localparam int CNT_W = $clog2(SAMPLE_W);

    logic             armed;            // waiting for the first bclk of the frame
    logic [CNT_W-1:0] bits_left;        // bits still to present after the current one
    sample_t          shreg;

    // i2s style, msb goes out one bclk after the left frame starts
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            armed     <= 1'b0;
            bits_left <= '0;
            shreg     <= '0;
            o_dac_dat <= 1'b0;
        end else if (i_lrck_fall) begin
            armed     <= 1'b1;
            o_dac_dat <= 1'b0;
        end else if (i_bclk_fall) begin
            if (armed) begin
                armed     <= 1'b0;
                shreg     <= i_sample;  // dsp output has settled by now
                o_dac_dat <= i_sample[SAMPLE_W-1];
                bits_left <= CNT_W'(SAMPLE_W - 1);
            end else if (bits_left != '0) begin
                shreg     <= shreg << 1;
                o_dac_dat <= shreg[SAMPLE_W-2];
                bits_left <= bits_left - 1'b1;
            end else begin
                o_dac_dat <= 1'b0;      // idle bits and right channel
            end
        end
    end

endmodule : aud_dac_tx

`default_nettype wire

// ==== hdl/aud_dsp.sv ====
`default_nettype none

module aud_dsp
    import aud_fmt_pkg::*;
    import aud_play_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_pause,
    input  logic       i_stop,
    input  logic       i_fast,          // 1 skips samples, 0 repeats them
    input  speed_t     i_speed,
    input  logic       i_interp,        // INTERP_CONST or INTERP_LINEAR
    input  logic       i_lrck_fall,     // left frame starts
    input  sample_t    i_sram_data,
    output sram_addr_t o_sram_addr,
    output sample_t    o_sample
);

    localparam int CALC_W = SAMPLE_W + 4;   // headroom for diff times count

    play_state_t state_r, state_w;
    sram_addr_t  addr_r, addr_w;
    sample_t     prev_r, prev_w;            // sample at the start of the segment
    sample_t     out_r, out_w;
    speed_t      rep_cnt_r, rep_cnt_w;      // repeat index inside a slow group
    speed_t      spd;                       // speed with 0 mapped to 1

    logic signed [CALC_W-1:0] diff;
    logic signed [CALC_W-1:0] prod;
    logic signed [CALC_W-1:0] quot;
    logic signed [CALC_W-1:0] interp_sum;
    sample_t                  interp_sample;
    logic                     group_end;

    assign o_sram_addr = addr_r;
    assign o_sample    = out_r;

    // linear ramp, prev + (cur - prev) * k / speed
    always_comb begin
        spd        = (i_speed == '0) ? speed_t'(1) : i_speed;
        diff       = CALC_W'(i_sram_data) - CALC_W'(prev_r);
        prod       = diff * $signed({1'b0, rep_cnt_r});
        quot       = prod / $signed({1'b0, spd});     // truncates toward zero
        interp_sum = CALC_W'(prev_r) + quot;
        interp_sample = sample_t'(interp_sum[SAMPLE_W-1:0]);  // wraps to 16 bits
        group_end  = (rep_cnt_r >= spd - 1'b1);
    end

    always_comb begin
        state_w   = state_r;
        addr_w    = addr_r;
        prev_w    = prev_r;
        out_w     = out_r;
        rep_cnt_w = rep_cnt_r;

        case (state_r)
            S_IDLE: begin
                if (i_start) begin          // address is 0 here
                    prev_w    = i_sram_data;
                    rep_cnt_w = '0;
                    addr_w    = i_fast ? ADDR_W'(spd) : ADDR_W'(1);
                    state_w   = S_PLAY;
                end
            end

            S_PAUSE: begin
                if (!i_pause) begin
                    state_w = S_PLAY;
                end
            end

            S_PLAY: begin
                if (i_stop) begin           // wins over pause and frame step
                    state_w = S_IDLE;
                    addr_w  = '0;
                end else begin
                    if (i_pause) begin
                        state_w = S_PAUSE;
                    end
                    if (i_lrck_fall) begin
                        if (i_fast) begin
                            out_w  = prev_r;
                            prev_w = i_sram_data;
                            addr_w = addr_r + ADDR_W'(spd);
                        end else begin
                            if (i_interp == INTERP_LINEAR) begin
                                out_w = interp_sample;
                            end else begin
                                out_w = prev_r;
                            end
                            if (group_end) begin
                                rep_cnt_w = '0;
                                addr_w    = addr_r + ADDR_W'(1);
                                prev_w    = i_sram_data;
                            end else begin
                                rep_cnt_w = rep_cnt_r + 1'b1;
                            end
                        end
                    end
                end
            end

            default: begin
                state_w = S_IDLE;           // unused encoding
                addr_w  = '0;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r   <= S_IDLE;
            addr_r    <= '0;
            prev_r    <= '0;
            out_r     <= '0;
            rep_cnt_r <= '0;
        end else begin
            state_r   <= state_w;
            addr_r    <= addr_w;
            prev_r    <= prev_w;
            out_r     <= out_w;
            rep_cnt_r <= rep_cnt_w;
        end
    end

endmodule : aud_dsp

`default_nettype wire

// ==== hdl/aud_clk_gen.sv ====
`default_nettype none

module aud_clk_gen
    import aud_fmt_pkg::*;
#(
    parameter int BCLK_HALF = 2             // i_clk cycles per half bclk period
) (
    input  logic i_clk,
    input  logic i_rst_n,
    output logic o_bclk,
    output logic o_lrck,
    output logic o_bclk_fall,
    output logic o_lrck_fall
);

    localparam int HALF_W    = (BCLK_HALF > 1) ? $clog2(BCLK_HALF) : 1;
    localparam int BIT_CNT_W = $clog2(2 * FRAME_BITS);  // bclk periods per frame

    localparam logic [HALF_W-1:0]    HALF_LAST  = HALF_W'(BCLK_HALF - 1);
    localparam logic [BIT_CNT_W-1:0] LEFT_LAST  = BIT_CNT_W'(FRAME_BITS - 1);
    localparam logic [BIT_CNT_W-1:0] FRAME_LAST = BIT_CNT_W'(2 * FRAME_BITS - 1);

    logic [HALF_W-1:0]    half_cnt;         // i_clk cycles within a bclk half
    logic [BIT_CNT_W-1:0] bit_cnt;          // bclk periods within the frame
    logic                 half_done;
    logic                 lrck_edge;

    assign half_done = (half_cnt == HALF_LAST);
    assign lrck_edge = (bit_cnt == LEFT_LAST) || (bit_cnt == FRAME_LAST);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            half_cnt    <= '0;
            bit_cnt     <= '0;
            o_bclk      <= 1'b0;
            o_lrck      <= 1'b0;
            o_bclk_fall <= 1'b0;
            o_lrck_fall <= 1'b0;
        end else begin
            o_bclk_fall <= 1'b0;            // strobes last one cycle
            o_lrck_fall <= 1'b0;
            if (half_done) begin
                half_cnt <= '0;
                o_bclk   <= ~o_bclk;
                if (o_bclk) begin           // bclk going low this edge
                    o_bclk_fall <= 1'b1;
                    bit_cnt     <= bit_cnt + 1'b1;
                    if (lrck_edge) begin
                        o_lrck      <= ~o_lrck;
                        o_lrck_fall <= o_lrck;  // only the high to low change
                    end
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule : aud_clk_gen

`default_nettype wire

// ==== hdl/aud_play_pkg.sv ====
`default_nettype none

package aud_play_pkg;

    // playback control fsm
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,                 // stopped, address parked at 0
        S_PLAY  = 2'd1,                 // advancing once per left frame
        S_PAUSE = 2'd2                  // frozen until pause drops
    } play_state_t;

    // speed factor, skip count when fast, repeat count when slow
    localparam int SPEED_W = 3;
    typedef logic [SPEED_W-1:0] speed_t;

    // interpolation select for slow playback
    localparam logic INTERP_CONST  = 1'b0;  // hold previous sample
    localparam logic INTERP_LINEAR = 1'b1;  // ramp between neighbours

endpackage : aud_play_pkg

`default_nettype wire

// ==== hdl/aud_fmt_pkg.sv ====
`default_nettype none

package aud_fmt_pkg;

    // audio word format
    localparam int SAMPLE_W = 16;       // bits per pcm sample
    localparam int ADDR_W   = 20;       // sram word address, 1M words

    // dac framing
    localparam int FRAME_BITS = 16;     // bclk periods per channel half-frame

    // two's complement pcm sample as stored in sram
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // word address into the sample sram
    typedef logic [ADDR_W-1:0] sram_addr_t;

endpackage : aud_fmt_pkg

`default_nettype wire
